//--- lin_cfg.svh
// widths, register map and reset values of the linear transform
`ifndef LIN_CFG_SVH
`define LIN_CFG_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

`define LIN_DWI 14          // input sample bits
`define LIN_DWO 14          // output sample bits
`define LIN_DWM 16          // gain bits
`define LIN_DWS `LIN_DWO    // offset spans the output range

////////////////////////////////////////
// register map
////////////////////////////////////////

`define LIN_AW          2      // register address bits
`define LIN_REG_W       16     // register data word
`define LIN_ADDR_GAIN   2'd0
`define LIN_ADDR_OFFSET 2'd1
`define LIN_ADDR_SATCNT 2'd2   // write clears

`define LIN_GAIN_RST   (1 << (`LIN_DWM-2))  // unity gain
`define LIN_OFFSET_RST 0
`define LIN_CNT_W      16      // clip counter bits

`endif

//--- lin_pkg.sv
// sample, gain, offset, product, sum and register word types
`include "lin_cfg.svh"

package lin_pkg;

  // stream samples
  typedef logic signed [`LIN_DWI-1:0] sample_in_t;
  typedef logic signed [`LIN_DWO-1:0] sample_out_t;

  // configuration values
  typedef logic signed [`LIN_DWM-1:0] gain_t;    // 2**(DWM-2) is unity
  typedef logic signed [`LIN_DWS-1:0] offset_t;

  // full precision product of sample and gain
  typedef logic signed [`LIN_DWI+`LIN_DWM-1:0] product_t;

  // product after the fixed point shift
  // keeps two bits above the input range
  typedef logic signed [`LIN_DWI+2-1:0] shifted_t;

  // shifted product plus offset
  // same width, result is truncated like the shifted value
  typedef logic signed [`LIN_DWI+2-1:0] sum_t;

  // register port word
  typedef logic [`LIN_REG_W-1:0] reg_data_t;

endpackage : lin_pkg

//--- lin_stage.sv
// handshaked pipeline register with payload type parameter

module lin_stage #(
  parameter type DAT_T = logic   // payload carried by the stage
) (
  input  logic sti,     // clock
  input  logic rst_n,
  // upstream side
  input  DAT_T i_dat,
  input  logic i_vld,
  output logic i_rdy,
  // downstream side
  output DAT_T o_dat,
  output logic o_vld,
  input  logic o_rdy
);

  logic i_trn;  // sample taken this edge

  // a bubble is always accepted
  assign i_rdy = o_rdy | ~o_vld;
  assign i_trn = i_vld & i_rdy;

  ////////////////////////////////////////
  // valid and payload
  ////////////////////////////////////////

  always_ff @(posedge sti or negedge rst_n) begin
    if (!rst_n) begin
      o_vld <= 1'b0;
    end else if (i_rdy) begin
      o_vld <= i_vld;   // drains or refills
    end
  end

  always_ff @(posedge sti) begin
    if (i_trn) begin
      o_dat <= i_dat;   // payload only moves on transfer
    end
  end

  // a stalled output keeps its sample until downstream takes it
  a_hold_stalled: assert property (
    @(posedge sti) disable iff (!rst_n)
    (o_vld && !o_rdy) |=> (o_vld && $stable(o_dat))
  ) else $error("stage output changed while stalled");

endmodule : lin_stage

//--- lin_gain.sv
// gain stage: registered product, then fixed point shift
`include "lin_cfg.svh"

module lin_gain import lin_pkg::*; (
  input  logic       sti,
  input  logic       rst_n,
  // sample stream in
  input  sample_in_t in_dat,
  input  logic       in_vld,
  output logic       in_rdy,
  // gain from register bank
  input  gain_t      gain,
  // shifted stream out
  output shifted_t   gain_dat,
  output logic       gain_vld,
  input  logic       gain_rdy
);

  product_t prod_d;    // sample times gain
  product_t prod_q;    // registered product
  product_t prod_shf;  // after the arithmetic shift

  ////////////////////////////////////////
  // multiply
  ////////////////////////////////////////

  // both operands signed, full width result
  assign prod_d = in_dat * gain;

  lin_stage #(
    .DAT_T (product_t)
  ) prod_stage (
    .sti   (sti),
    .rst_n (rst_n),
    .i_dat (prod_d),
    .i_vld (in_vld),
    .i_rdy (in_rdy),
    .o_dat (prod_q),
    .o_vld (gain_vld),   // shift adds no register
    .o_rdy (gain_rdy)
  );

  ////////////////////////////////////////
  // shift
  ////////////////////////////////////////

  // unity gain sits at 2**(DWM-2)
  assign prod_shf = prod_q >>> (`LIN_DWM-2);

  // keep low bits only, upper ones are sign copies for sane gains
  assign gain_dat = prod_shf[$bits(shifted_t)-1:0];

endmodule : lin_gain

//--- lin_offset_sat.sv
// offset stage and saturation stage with clip event
`include "lin_cfg.svh"

module lin_offset_sat import lin_pkg::*; (
  input  logic        sti,
  input  logic        rst_n,
  // shifted stream in
  input  shifted_t    gain_dat,
  input  logic        gain_vld,
  output logic        gain_rdy,
  // offset from register bank
  input  offset_t     offset,
  // saturated stream out
  output sample_out_t out_dat,
  output logic        out_vld,
  input  logic        out_rdy,
  // clip pulse to the counter
  output logic        sat_evt
);

  localparam int SW = $bits(sum_t);

  sum_t                 sum_d;    // shifted value plus offset
  sum_t                 sum_q;
  logic                 sum_vld;
  logic                 sum_rdy;
  logic [SW-`LIN_DWO:0] sum_hi;   // bits that must agree with the sign
  logic                 clip;
  sample_out_t          sat_d;

  ////////////////////////////////////////
  // offset
  ////////////////////////////////////////

  assign sum_d = gain_dat + offset;   // offset sign extended

  lin_stage #(
    .DAT_T (sum_t)
  ) sum_stage (
    .sti   (sti),
    .rst_n (rst_n),
    .i_dat (sum_d),
    .i_vld (gain_vld),
    .i_rdy (gain_rdy),
    .o_dat (sum_q),
    .o_vld (sum_vld),
    .o_rdy (sum_rdy)
  );

  ////////////////////////////////////////
  // saturation
  ////////////////////////////////////////

  assign sum_hi = sum_q[SW-1:`LIN_DWO-1];
  assign clip   = ~((&sum_hi) | ~(|sum_hi));  // neither all ones nor all zeros

  // clip toward the sign of the sum
  assign sat_d = clip ? {sum_q[SW-1], {(`LIN_DWO-1){~sum_q[SW-1]}}}
                      : sum_q[`LIN_DWO-1:0];

  lin_stage #(
    .DAT_T (sample_out_t)
  ) sat_stage (
    .sti   (sti),
    .rst_n (rst_n),
    .i_dat (sat_d),
    .i_vld (sum_vld),
    .i_rdy (sum_rdy),
    .o_dat (out_dat),
    .o_vld (out_vld),
    .o_rdy (out_rdy)
  );

  // high in the cycle a clipped sample first sits in the output register
  always_ff @(posedge sti or negedge rst_n) begin
    if (!rst_n) begin
      sat_evt <= 1'b0;
    end else begin
      sat_evt <= sum_vld & sum_rdy & clip;
    end
  end

  // pulse only after the output register took a rail value
  a_evt_on_transfer: assert property (
    @(posedge sti) disable iff (!rst_n)
    sat_evt |-> (out_vld && $past(out_rdy || !out_vld) &&
                 (out_dat == {1'b0, {(`LIN_DWO-1){1'b1}}} ||
                  out_dat == {1'b1, {(`LIN_DWO-1){1'b0}}}))
  ) else $error("clip event without a sample entering the output stage");

endmodule : lin_offset_sat

//--- lin_ctrl.sv
// gain and offset registers, clip counter and registered readback
`include "lin_cfg.svh"

module lin_ctrl import lin_pkg::*; (
  input  logic               sti,
  input  logic               rst_n,
  // register port
  input  logic               reg_we,
  input  logic [`LIN_AW-1:0] reg_addr,
  input  reg_data_t          reg_wdata,
  output reg_data_t          reg_rdata,
  // configuration to datapath
  output gain_t              gain,
  output offset_t            offset,
  // clip pulse from datapath
  input  logic               sat_evt
);

  logic [`LIN_CNT_W-1:0] sat_cnt;   // clipped samples seen
  logic                  cnt_clr;   // write to counter address
  logic                  cnt_max;   // counter stuck at top

  assign cnt_clr = reg_we && (reg_addr == `LIN_ADDR_SATCNT);
  assign cnt_max = &sat_cnt;

  ////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////

  always_ff @(posedge sti or negedge rst_n) begin
    if (!rst_n) begin
      gain   <= gain_t'(`LIN_GAIN_RST);     // unity
      offset <= offset_t'(`LIN_OFFSET_RST);
    end else if (reg_we) begin
      case (reg_addr)
        `LIN_ADDR_GAIN:   gain   <= gain_t'(reg_wdata);
        `LIN_ADDR_OFFSET: offset <= offset_t'(reg_wdata[`LIN_DWS-1:0]);  // upper bits dropped
        default: ;
      endcase
    end
  end

  // clip counter, clear wins over a same cycle event
  always_ff @(posedge sti or negedge rst_n) begin
    if (!rst_n) begin
      sat_cnt <= '0;
    end else if (cnt_clr) begin
      sat_cnt <= '0;
    end else if (sat_evt && !cnt_max) begin
      sat_cnt <= sat_cnt + 1'b1;   // stops at all ones
    end
  end

  ////////////////////////////////////////
  // readback
  ////////////////////////////////////////

  always_ff @(posedge sti or negedge rst_n) begin
    if (!rst_n) begin
      reg_rdata <= '0;
    end else begin
      case (reg_addr)
        `LIN_ADDR_GAIN:   reg_rdata <= reg_data_t'(gain);
        `LIN_ADDR_OFFSET: reg_rdata <= reg_data_t'(offset);   // sign extended
        `LIN_ADDR_SATCNT: reg_rdata <= reg_data_t'(sat_cnt);
        default:          reg_rdata <= '0;   // unmapped
      endcase
    end
  end

  // saturating counter only returns to zero through a clear
  a_cnt_no_wrap: assert property (
    @(posedge sti) disable iff (!rst_n)
    cnt_max |=> ((sat_cnt != '0) || $past(cnt_clr))
  ) else $error("clip counter wrapped from its maximum");

endmodule : lin_ctrl

//--- lin_top.sv
// linear transform top with register bank, gain and offset/saturation stages
`include "lin_cfg.svh"

module lin_top import lin_pkg::*; (
  input  logic               sti,
  input  logic               rst_n,
  // sample stream in
  input  sample_in_t         in_dat,
  input  logic               in_vld,
  output logic               in_rdy,
  // sample stream out
  output sample_out_t        out_dat,
  output logic               out_vld,
  input  logic               out_rdy,
  // register port
  input  logic               reg_we,
  input  logic [`LIN_AW-1:0] reg_addr,
  input  reg_data_t          reg_wdata,
  output reg_data_t          reg_rdata
);

  gain_t    gain;       // from register bank
  offset_t  offset;
  shifted_t gain_dat;   // between the two datapath blocks
  logic     gain_vld;
  logic     gain_rdy;
  logic     sat_evt;    // clip pulse back to the counter

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  lin_ctrl ctrl_inst (
    .sti       (sti),
    .rst_n     (rst_n),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .gain      (gain),
    .offset    (offset),
    .sat_evt   (sat_evt)
  );

  ////////////////////////////////////////
  // datapath, three register stages
  ////////////////////////////////////////

  lin_gain gain_inst (
    .sti      (sti),
    .rst_n    (rst_n),
    .in_dat   (in_dat),
    .in_vld   (in_vld),
    .in_rdy   (in_rdy),
    .gain     (gain),
    .gain_dat (gain_dat),
    .gain_vld (gain_vld),
    .gain_rdy (gain_rdy)
  );

  lin_offset_sat offset_sat_inst (
    .sti      (sti),
    .rst_n    (rst_n),
    .gain_dat (gain_dat),
    .gain_vld (gain_vld),
    .gain_rdy (gain_rdy),
    .offset   (offset),
    .out_dat  (out_dat),
    .out_vld  (out_vld),
    .out_rdy  (out_rdy),
    .sat_evt  (sat_evt)
  );

endmodule : lin_top

//--- tb_lin_top.sv
// lin_top testbench with clock, reset, random stimulus, reference queue, assertions and watchdog
`include "lin_cfg.svh"

module tb_lin_top import lin_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_UNITY = 20;   // unity pass-through samples
  localparam int N_ROUND = 25;   // samples per random config
  localparam int ROUNDS  = 4;
  localparam int N_CLIP  = 30;   // per clip direction
  // at most four cycles per sample plus register traffic and drains
  localparam int WD_CYCLES = 10 + 4 * (N_UNITY + ROUNDS * N_ROUND + 2 * N_CLIP) + 400;

  logic               sti;
  logic               rst_n;
  sample_in_t         in_dat;
  logic               in_vld;
  logic               in_rdy;
  sample_out_t        out_dat;
  logic               out_vld;
  logic               out_rdy;
  logic               reg_we;
  logic [`LIN_AW-1:0] reg_addr;
  reg_data_t          reg_wdata;
  reg_data_t          reg_rdata;

  sample_out_t exp_q[$];     // expected outputs in acceptance order
  int          stamp_q[$];   // edge number of each acceptance
  sample_out_t exp_head;
  sample_out_t exp_val;
  int          head_stamp;
  int          exp_cnt;      // samples inside the pipeline
  int          edge_no;
  int          n_acc;
  int          n_clip;       // clips predicted by the model
  bit          clip_flag;
  int          m_gain;       // gain and offset in force
  int          m_off;
  bit          rdy_rand;     // random back-pressure on
  bit          lat_chk;      // fixed latency expected
  bit          rd_chk;
  reg_data_t   rd_exp;
  int          n_mismatch;
  int          n_other;

  lin_top lin_top_inst (.*);

  initial begin
    sti = 1'b0;
    forever #50 sti = ~sti;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // gain, shift by DWM-2, add offset, clamp to output range
  function automatic sample_out_t model_out(input int s, input int g, input int o,
                                            output bit clipped);
    longint   prod;
    shifted_t shf;
    sum_t     sum;
    longint   hi;
    longint   lo;
    hi      = (longint'(1) <<< (`LIN_DWO - 1)) - 1;
    lo      = -hi - 1;
    prod    = longint'(s) * g;
    shf     = shifted_t'(prod >>> (`LIN_DWM - 2));   // low DWI+2 bits kept
    sum     = sum_t'(longint'(shf) + o);
    clipped = 1'b1;
    if (sum > hi) return sample_out_t'(hi);
    if (sum < lo) return sample_out_t'(lo);
    clipped = 1'b0;
    return sample_out_t'(sum);
  endfunction

  function automatic int rand_between(input int lo, input int hi);
    return lo + int'($urandom_range(hi - lo));
  endfunction

  // sees pre-edge DUT values since flops update in NBA
  always @(posedge sti) begin
    if (rst_n) begin
      if (out_vld && out_rdy && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        void'(stamp_q.pop_front());
      end
      if (in_vld && in_rdy) begin
        exp_val = model_out(in_dat, m_gain, m_off, clip_flag);
        exp_q.push_back(exp_val);
        stamp_q.push_back(edge_no);
        if (clip_flag) n_clip++;
        n_acc++;
      end
    end
    edge_no++;
    exp_cnt = exp_q.size();
    if (exp_cnt != 0) begin
      exp_head   = exp_q[0];
      head_stamp = stamp_q[0];
    end
  end

  // back-pressure is random or held high
  always @(negedge sti) out_rdy = rdy_rand ? ($urandom_range(1) != 0) : 1'b1;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_reset_idle: assert property (@(posedge sti) !rst_n |-> !out_vld)
    else begin
      n_other++;
      $display("output valid during reset at %0t", $time);
    end

  a_out_value: assert property (@(posedge sti) disable iff (!rst_n)
    (out_vld && out_rdy && exp_cnt != 0) |-> out_dat == exp_head)
    else begin
      n_mismatch++;
      $display("MISMATCH t=%0t out_dat expected %0d actual %0d", $time,
               $sampled(exp_head), $sampled(out_dat));
    end

  a_no_extra: assert property (@(posedge sti) disable iff (!rst_n)
    (out_vld && out_rdy) |-> exp_cnt != 0)
    else begin
      n_other++;
      $display("sample delivered that was never sent at %0t", $time);
    end

  a_stall_hold: assert property (@(posedge sti) disable iff (!rst_n)
    (out_vld && !out_rdy) |=> (out_vld && $stable(out_dat)))
    else begin
      n_other++;
      $display("stalled output changed at %0t", $time);
    end

  a_full_only: assert property (@(posedge sti) disable iff (!rst_n) !in_rdy |-> exp_cnt == 3)
    else begin
      n_other++;
      $display("input not ready with %0d held at %0t", $sampled(exp_cnt), $time);
    end

  // output transfer lands exactly on the third edge after acceptance
  a_latency: assert property (@(posedge sti) disable iff (!rst_n)
    (lat_chk && exp_cnt != 0) |-> ((out_vld && out_rdy) == ((edge_no - head_stamp) == 3)))
    else begin
      n_other++;
      $display("sample not delivered three cycles on at %0t", $time);
    end

  a_readback: assert property (@(posedge sti) disable iff (!rst_n) rd_chk |=> reg_rdata == rd_exp)
    else begin
      n_mismatch++;
      $display("MISMATCH t=%0t reg_rdata expected %h actual %h", $time,
               $sampled(rd_exp), $sampled(reg_rdata));
    end

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  task automatic write_reg(input logic [`LIN_AW-1:0] addr, input int val);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = reg_data_t'(val);
    @(negedge sti);
    reg_we = 1'b0;
    if (addr == `LIN_ADDR_GAIN) m_gain = val;
    if (addr == `LIN_ADDR_OFFSET) m_off = val;
  endtask

  task automatic read_check(input logic [`LIN_AW-1:0] addr, input int val);
    reg_addr = addr;
    rd_exp   = reg_data_t'(val);   // offset comes back sign extended
    rd_chk   = 1'b1;
    @(negedge sti);
    rd_chk = 1'b0;
    @(negedge sti);
  endtask

  task automatic send(input int s);
    int taken;
    taken  = n_acc;
    in_dat = sample_in_t'(s);
    in_vld = 1'b1;
    @(negedge sti);
    while (n_acc == taken) @(negedge sti);   // held until accepted
    in_vld = 1'b0;
  endtask

  task automatic burst(input int n, input int amp);
    repeat (n) send(rand_between(-amp, amp - 1));
  endtask

  task automatic drain();
    while (exp_cnt != 0) @(negedge sti);
    repeat (2) @(negedge sti);   // clip pulse reaches the counter
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(1523));
    rst_n     = 1'b0;
    in_dat    = '0;
    in_vld    = 1'b0;
    out_rdy   = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    m_gain    = `LIN_GAIN_RST;
    m_off     = `LIN_OFFSET_RST;
    repeat (10) @(negedge sti);
    rst_n = 1'b1;
    @(negedge sti);
    read_check(`LIN_ADDR_GAIN, `LIN_GAIN_RST);
    read_check(`LIN_ADDR_OFFSET, 0);
    read_check(`LIN_ADDR_SATCNT, 0);
    read_check(2'd3, 0);   // unmapped
    lat_chk = 1'b1;
    burst(N_UNITY, 8192);   // full input range passes unchanged at unity
    drain();
    lat_chk = 1'b0;
    for (int r = 0; r < ROUNDS; r++) begin
      // |gain| up to unity and small samples keep clear of the rails
      write_reg(`LIN_ADDR_GAIN, rand_between(-16384, 16384));
      write_reg(`LIN_ADDR_OFFSET, rand_between(-2048, 2047));
      read_check(`LIN_ADDR_GAIN, m_gain);
      read_check(`LIN_ADDR_OFFSET, m_off);
      rdy_rand = r[0];
      lat_chk  = !r[0];
      burst(N_ROUND, 4096);
      drain();
      lat_chk = 1'b0;
    end
    rdy_rand = 1'b1;
    write_reg(`LIN_ADDR_SATCNT, 0);
    n_clip = 0;
    write_reg(`LIN_ADDR_GAIN, 32767);   // near double gain
    write_reg(`LIN_ADDR_OFFSET, 6000);
    burst(N_CLIP, 8192);
    drain();
    write_reg(`LIN_ADDR_GAIN, -32768);
    write_reg(`LIN_ADDR_OFFSET, -6000);
    burst(N_CLIP, 8192);
    drain();
    read_check(`LIN_ADDR_SATCNT, n_clip);
    write_reg(`LIN_ADDR_SATCNT, 0);   // clear
    read_check(`LIN_ADDR_SATCNT, 0);
    rdy_rand = 1'b0;
    repeat (2) @(negedge sti);
    $display("errors: %0d mismatch, %0d other", n_mismatch, n_other);
    if (n_mismatch + n_other == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // watchdog
  initial begin
    #(WD_CYCLES * 100);
    $display("timeout: the sample stream stopped moving at %0t", $time);
    $display("errors: %0d mismatch, %0d other", n_mismatch, n_other);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : tb_lin_top

//--- lin_top.f
+incdir+.
lin_pkg.sv
lin_stage.sv
lin_gain.sv
lin_offset_sat.sv
lin_ctrl.sv
lin_top.sv
tb_lin_top.sv

//--- Bender.yml
package:
  name: lin_top

export_include_dirs:
  - .

sources:
  - lin_pkg.sv
  - lin_stage.sv
  - lin_gain.sv
  - lin_offset_sat.sv
  - lin_ctrl.sv
  - lin_top.sv
  - target: simulation
    files:
      - tb_lin_top.sv
